//--- sim.f
+incdir+src
src/mmio_pkg.sv
src/mmio_controller.sv
src/mmio_gpo.sv
src/mmio_ddfs.sv
src/ddfs_core.sv
src/mmio_adsr.sv
src/adsr_core.sv
src/mmio_top.sv
tb/mmio_checker.sv
tb/tb_mmio_top.sv

//--- src/adsr_core.sv
`timescale 1ns/100ps
`default_nettype none
`include "io_mmio_map_defs.svh"

module adsr_core
    import mmio_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_arst_n,
    input  logic        i_sample_tick,
    input  logic        i_start,
    input  logic        i_release,
    input  logic [15:0] i_attack_step,
    input  logic [15:0] i_decay_step,
    input  logic [15:0] i_sustain_lvl,
    input  logic [15:0] i_release_step,
    output logic [15:0] o_env,
    output adsr_state_e o_state
);

    logic [15:0] sustain;
    logic [16:0] env_up;
    logic [16:0] env_decay;
    logic [16:0] env_rel;

    // Sustain above the ceiling behaves as the ceiling
    assign sustain = (i_sustain_lvl > `ENV_MAX) ? `ENV_MAX : i_sustain_lvl;

    // Bit 16 catches overflow and borrow
    assign env_up    = {1'b0, o_env} + {1'b0, i_attack_step};
    assign env_decay = {1'b0, o_env} - {1'b0, i_decay_step};
    assign env_rel   = {1'b0, o_env} - {1'b0, i_release_step};

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_state <= ADSR_IDLE;
            o_env   <= '0;
        end else if (i_start) begin
            o_state <= ADSR_ATTACK;
        end else if (i_release && o_state != ADSR_IDLE) begin
            o_state <= ADSR_RELEASE;
        end else if (i_sample_tick) begin
            case (o_state)
                ADSR_ATTACK: begin
                    if (env_up >= {1'b0, `ENV_MAX}) begin
                        o_env   <= `ENV_MAX;
                        o_state <= ADSR_DECAY;
                    end else begin
                        o_env <= env_up[15:0];
                    end
                end
                ADSR_DECAY: begin
                    if (env_decay[16] || env_decay[15:0] <= sustain) begin
                        o_env   <= sustain;
                        o_state <= ADSR_SUSTAIN;
                    end else begin
                        o_env <= env_decay[15:0];
                    end
                end
                ADSR_RELEASE: begin
                    if (env_rel[16] || env_rel[15:0] == '0) begin
                        o_env   <= '0;
                        o_state <= ADSR_IDLE;
                    end else begin
                        o_env <= env_rel[15:0];
                    end
                end
                // Idle and sustain hold
                default: ;
            endcase
        end
    end

    a_env_ceiling: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        o_env <= `ENV_MAX
    ) else $error("Envelope above ceiling");

    a_idle_silent: assert property (
        @(posedge i_clk) disable iff (!i_arst_n)
        (o_state == ADSR_IDLE && !i_start) |-> (o_env == '0)
    ) else $error("Envelope not zero in idle");

endmodule

`default_nettype wire

//--- src/ddfs_core.sv
`timescale 1ns/100ps
`default_nettype none

module ddfs_core
    import mmio_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_arst_n,
    input  logic        i_sample_tick,
    input  logic [31:0] i_fcw,
    input  logic [31:0] i_poff,
    input  ddfs_wave_e  i_wave,
    input  logic [15:0] i_amp,
    input  logic [15:0] i_env_ext,
    input  logic        i_env_sel,
    output logic [15:0] o_pcm_out,
    output logic        o_pcm_valid
);

    logic [31:0]        phase;
    logic [31:0]        phase_off;
    logic signed [15:0] wave;
    logic [15:0]        gain;
    logic signed [32:0] product;

    assign phase_off = phase + i_poff;

    always_comb begin
        case (i_wave)
            WAVE_SQUARE: wave = phase_off[31] ? 16'sh8001 : 16'sh7FFF;
            default:     wave = $signed(phase_off[31:16]);
        endcase
    end

    // Amplitude is unsigned, so extend it with a zero sign bit
    assign gain    = i_env_sel ? i_env_ext : i_amp;
    assign product = wave * $signed({1'b0, gain});

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            phase       <= '0;
            o_pcm_out   <= '0;
            o_pcm_valid <= 1'b0;
        end else begin
            o_pcm_valid <= i_sample_tick;
            if (i_sample_tick) begin
                phase     <= phase + i_fcw;
                // Product >>> 15
                o_pcm_out <= product[30:15];
            end
        end
    end

endmodule

`default_nettype wire

//--- src/io_mmio_map_defs.svh
`ifndef IO_MMIO_MAP_DEFS_SVH
`define IO_MMIO_MAP_DEFS_SVH

// Bus and address fields
`define MMIO_ADDR_W         21
`define MMIO_DATA_W         32
`define MMIO_SLOT_LSB       5
`define MMIO_SLOT_W         6
`define MMIO_REG_W          5
`define MMIO_NUM_SLOTS      64

// Slot numbers
`define IO_S0_GPO           0
`define IO_S1_DDFS          1
`define IO_S2_ADSR          2

// DDFS registers
`define DDFS_REG_CTRL       0
`define DDFS_REG_FCW        1
`define DDFS_REG_POFF       2
`define DDFS_REG_AMP        3

// ADSR registers
`define ADSR_REG_ATTACK     0
`define ADSR_REG_DECAY      1
`define ADSR_REG_SUSTAIN    2
`define ADSR_REG_RELEASE    3
`define ADSR_REG_GATE       4
`define ADSR_REG_STATUS     5

`define ENV_MAX             16'h7FFF
`define UNUSED_SLOT_DATA    32'hFFFF_FFFF

`endif

//--- src/mmio_adsr.sv
`timescale 1ns/100ps
`default_nettype none
`include "io_mmio_map_defs.svh"

module mmio_adsr
    import mmio_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_cs,
    input  logic                    i_write,
    input  logic                    i_read,
    input  logic [`MMIO_REG_W-1:0]  i_addr,
    input  logic [`MMIO_DATA_W-1:0] i_write_data,
    output logic [`MMIO_DATA_W-1:0] o_read_data,
    // Envelope generator side
    input  logic [15:0]             i_env,
    input  adsr_state_e             i_state,
    output logic [15:0]             o_attack_step,
    output logic [15:0]             o_decay_step,
    output logic [15:0]             o_sustain_lvl,
    output logic [15:0]             o_release_step,
    output logic                    o_start,
    output logic                    o_release
);

    logic gate_wr;

    assign gate_wr = i_cs && i_write && (i_addr == `ADSR_REG_GATE);

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_attack_step  <= '0;
            o_decay_step   <= '0;
            o_sustain_lvl  <= '0;
            o_release_step <= '0;
        end else if (i_cs && i_write) begin
            case (i_addr)
                `ADSR_REG_ATTACK:  o_attack_step  <= i_write_data[15:0];
                `ADSR_REG_DECAY:   o_decay_step   <= i_write_data[15:0];
                `ADSR_REG_SUSTAIN: o_sustain_lvl  <= i_write_data[15:0];
                `ADSR_REG_RELEASE: o_release_step <= i_write_data[15:0];
                default: ;
            endcase
        end
    end

    // Gate writes become one-cycle pulses
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_start   <= 1'b0;
            o_release <= 1'b0;
        end else begin
            o_start   <= gate_wr && i_write_data[0];
            o_release <= gate_wr && i_write_data[1];
        end
    end

    always_comb begin
        o_read_data = '0;
        if (i_cs && i_read) begin
            case (i_addr)
                `ADSR_REG_ATTACK:  o_read_data = {16'd0, o_attack_step};
                `ADSR_REG_DECAY:   o_read_data = {16'd0, o_decay_step};
                `ADSR_REG_SUSTAIN: o_read_data = {16'd0, o_sustain_lvl};
                `ADSR_REG_RELEASE: o_read_data = {16'd0, o_release_step};
                `ADSR_REG_STATUS:  o_read_data = {13'd0, i_state, i_env};
                default:           o_read_data = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/mmio_controller.sv
`timescale 1ns/100ps
`default_nettype none
`include "io_mmio_map_defs.svh"

module mmio_controller (
    input  logic                                     i_mmio_cs,
    input  logic                                     i_mmio_write,
    input  logic                                     i_mmio_read,
    input  logic [`MMIO_ADDR_W-1:0]                  i_mmio_addr,
    input  logic [`MMIO_DATA_W-1:0]                  i_mmio_write_data,
    output logic [`MMIO_DATA_W-1:0]                  o_mmio_read_data,
    // Slot side
    output logic [`MMIO_NUM_SLOTS-1:0]               o_slot_cs,
    output logic [`MMIO_NUM_SLOTS-1:0]               o_slot_read,
    output logic [`MMIO_NUM_SLOTS-1:0]               o_slot_write,
    output logic [`MMIO_REG_W-1:0]                   o_slot_reg_addr,
    output logic [`MMIO_DATA_W-1:0]                  o_slot_write_data,
    input  logic [`MMIO_NUM_SLOTS*`MMIO_DATA_W-1:0]  i_slot_read_data
);

    logic [`MMIO_SLOT_W-1:0] slot;

    assign slot              = i_mmio_addr[`MMIO_SLOT_LSB +: `MMIO_SLOT_W];
    assign o_slot_reg_addr   = i_mmio_addr[`MMIO_REG_W-1:0];
    assign o_slot_write_data = i_mmio_write_data;

    // One-hot slot select
    always_comb begin
        o_slot_cs       = '0;
        o_slot_cs[slot] = i_mmio_cs;
    end

    assign o_slot_read  = i_mmio_read  ? o_slot_cs : '0;
    assign o_slot_write = i_mmio_write ? o_slot_cs : '0;

    // Read lane of the addressed slot
    assign o_mmio_read_data = i_slot_read_data[slot*`MMIO_DATA_W +: `MMIO_DATA_W];

    // Bus strobes checked after each update
    always_comb begin
        assert final (!(i_mmio_cs && i_mmio_read && i_mmio_write))
            else $error("Bus read and write strobes high together");
    end

endmodule

`default_nettype wire

//--- src/mmio_ddfs.sv
`timescale 1ns/100ps
`default_nettype none
`include "io_mmio_map_defs.svh"

module mmio_ddfs
    import mmio_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_cs,
    input  logic                    i_write,
    input  logic                    i_read,
    input  logic [`MMIO_REG_W-1:0]  i_addr,
    input  logic [`MMIO_DATA_W-1:0] i_write_data,
    output logic [`MMIO_DATA_W-1:0] o_read_data,
    // Tone generator settings
    output logic [31:0]             o_fcw,
    output logic [31:0]             o_poff,
    output ddfs_wave_e              o_wave,
    output logic [15:0]             o_amp,
    output logic                    o_env_sel
);

    logic [2:0] ctrl;

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            ctrl   <= '0;
            o_fcw  <= '0;
            o_poff <= '0;
            o_amp  <= '0;
        end else if (i_cs && i_write) begin
            case (i_addr)
                `DDFS_REG_CTRL: ctrl   <= i_write_data[2:0];
                `DDFS_REG_FCW:  o_fcw  <= i_write_data;
                `DDFS_REG_POFF: o_poff <= i_write_data;
                `DDFS_REG_AMP:  o_amp  <= i_write_data[15:0];
                default: ;
            endcase
        end
    end

    assign o_env_sel = ctrl[0];
    assign o_wave    = ddfs_wave_e'(ctrl[2:1]);

    always_comb begin
        o_read_data = '0;
        if (i_cs && i_read) begin
            case (i_addr)
                `DDFS_REG_CTRL: o_read_data = {29'd0, ctrl};
                `DDFS_REG_FCW:  o_read_data = o_fcw;
                `DDFS_REG_POFF: o_read_data = o_poff;
                `DDFS_REG_AMP:  o_read_data = {16'd0, o_amp};
                default:        o_read_data = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- src/mmio_gpo.sv
`timescale 1ns/100ps
`default_nettype none
`include "io_mmio_map_defs.svh"

module mmio_gpo (
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_cs,
    input  logic                    i_write,
    input  logic                    i_read,
    input  logic [`MMIO_REG_W-1:0]  i_addr,
    input  logic [`MMIO_DATA_W-1:0] i_write_data,
    output logic [`MMIO_DATA_W-1:0] o_read_data,
    output logic [`MMIO_DATA_W-1:0] o_gpo
);

    // Single register, the whole slot aliases onto it
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_gpo <= '0;
        end else if (i_cs && i_write) begin
            o_gpo <= i_write_data;
        end
    end

    assign o_read_data = (i_cs && i_read) ? o_gpo : '0;

endmodule

`default_nettype wire

//--- src/mmio_pkg.sv
`default_nettype none

package mmio_pkg;

    // Tone generator waveform, CTRL bits 2:1
    typedef enum logic [1:0] {
        WAVE_SAW    = 2'd0,
        WAVE_SQUARE = 2'd1
    } ddfs_wave_e;

    // Envelope generator state, STATUS bits 18:16
    typedef enum logic [2:0] {
        ADSR_IDLE    = 3'd0,
        ADSR_ATTACK  = 3'd1,
        ADSR_DECAY   = 3'd2,
        ADSR_SUSTAIN = 3'd3,
        ADSR_RELEASE = 3'd4
    } adsr_state_e;

endpackage

`default_nettype wire

//--- src/mmio_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "io_mmio_map_defs.svh"

module mmio_top
    import mmio_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    // MMIO bus
    input  logic                    i_mmio_cs,
    input  logic                    i_mmio_write,
    input  logic                    i_mmio_read,
    input  logic [`MMIO_ADDR_W-1:0] i_mmio_addr,
    input  logic [`MMIO_DATA_W-1:0] i_mmio_write_data,
    output logic [`MMIO_DATA_W-1:0] o_mmio_read_data,
    // External
    input  logic                    i_sample_tick,
    output logic [3:0]              o_led,
    output logic [15:0]             o_pcm_out,
    output logic                    o_pcm_valid
);

    logic [`MMIO_NUM_SLOTS-1:0]              slot_cs;
    logic [`MMIO_NUM_SLOTS-1:0]              slot_read;
    logic [`MMIO_NUM_SLOTS-1:0]              slot_write;
    logic [`MMIO_REG_W-1:0]                  slot_reg_addr;
    logic [`MMIO_DATA_W-1:0]                 slot_write_data;
    logic [`MMIO_NUM_SLOTS*`MMIO_DATA_W-1:0] slot_read_data;

    mmio_controller mmio_controller_unit (
        .i_mmio_cs         (i_mmio_cs),
        .i_mmio_write      (i_mmio_write),
        .i_mmio_read       (i_mmio_read),
        .i_mmio_addr       (i_mmio_addr),
        .i_mmio_write_data (i_mmio_write_data),
        .o_mmio_read_data  (o_mmio_read_data),
        .o_slot_cs         (slot_cs),
        .o_slot_read       (slot_read),
        .o_slot_write      (slot_write),
        .o_slot_reg_addr   (slot_reg_addr),
        .o_slot_write_data (slot_write_data),
        .i_slot_read_data  (slot_read_data)
    );

    // Slot 0, GPO
    logic [`MMIO_DATA_W-1:0] gpo;

    mmio_gpo mmio_gpo_unit (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_cs         (slot_cs[`IO_S0_GPO]),
        .i_write      (slot_write[`IO_S0_GPO]),
        .i_read       (slot_read[`IO_S0_GPO]),
        .i_addr       (slot_reg_addr),
        .i_write_data (slot_write_data),
        .o_read_data  (slot_read_data[`IO_S0_GPO*`MMIO_DATA_W +: `MMIO_DATA_W]),
        .o_gpo        (gpo)
    );

    assign o_led = gpo[3:0];

    // Slot 1, DDFS
    logic [31:0] fcw;
    logic [31:0] poff;
    ddfs_wave_e  wave;
    logic [15:0] amp;
    logic        env_sel;
    logic [15:0] env;

    mmio_ddfs mmio_ddfs_unit (
        .i_clk        (i_clk),
        .i_arst_n     (i_arst_n),
        .i_cs         (slot_cs[`IO_S1_DDFS]),
        .i_write      (slot_write[`IO_S1_DDFS]),
        .i_read       (slot_read[`IO_S1_DDFS]),
        .i_addr       (slot_reg_addr),
        .i_write_data (slot_write_data),
        .o_read_data  (slot_read_data[`IO_S1_DDFS*`MMIO_DATA_W +: `MMIO_DATA_W]),
        .o_fcw        (fcw),
        .o_poff       (poff),
        .o_wave       (wave),
        .o_amp        (amp),
        .o_env_sel    (env_sel)
    );

    ddfs_core ddfs_core_unit (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_sample_tick (i_sample_tick),
        .i_fcw         (fcw),
        .i_poff        (poff),
        .i_wave        (wave),
        .i_amp         (amp),
        .i_env_ext     (env),
        .i_env_sel     (env_sel),
        .o_pcm_out     (o_pcm_out),
        .o_pcm_valid   (o_pcm_valid)
    );

    // Slot 2, ADSR
    logic [15:0] attack_step;
    logic [15:0] decay_step;
    logic [15:0] sustain_lvl;
    logic [15:0] release_step;
    logic        start;
    logic        release_cmd;
    adsr_state_e state;

    mmio_adsr mmio_adsr_unit (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_cs           (slot_cs[`IO_S2_ADSR]),
        .i_write        (slot_write[`IO_S2_ADSR]),
        .i_read         (slot_read[`IO_S2_ADSR]),
        .i_addr         (slot_reg_addr),
        .i_write_data   (slot_write_data),
        .o_read_data    (slot_read_data[`IO_S2_ADSR*`MMIO_DATA_W +: `MMIO_DATA_W]),
        .i_env          (env),
        .i_state        (state),
        .o_attack_step  (attack_step),
        .o_decay_step   (decay_step),
        .o_sustain_lvl  (sustain_lvl),
        .o_release_step (release_step),
        .o_start        (start),
        .o_release      (release_cmd)
    );

    adsr_core adsr_core_unit (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_sample_tick  (i_sample_tick),
        .i_start        (start),
        .i_release      (release_cmd),
        .i_attack_step  (attack_step),
        .i_decay_step   (decay_step),
        .i_sustain_lvl  (sustain_lvl),
        .i_release_step (release_step),
        .o_env          (env),
        .o_state        (state)
    );

    // Unused slots read back all ones
    for (genvar i = 3; i < `MMIO_NUM_SLOTS; i++) begin : g_unused_slot
        assign slot_read_data[i*`MMIO_DATA_W +: `MMIO_DATA_W] = `UNUSED_SLOT_DATA;
    end

endmodule

`default_nettype wire

//--- tb/mmio_cases.txt
# kind name slot reg value: W writes value, R reads and expects value (all hex)
# T name count gap 0: count sample ticks, 0 to gap idle cycles between them (hex)
R rd_gpo_rst      0  0  00000000
R rd_fcw_rst      1  1  00000000
R rd_status_rst   2  5  00000000
W wr_gpo          0  0  A5A55A5C
R rd_gpo          0  0  A5A55A5C
R rd_gpo_alias    0  7  A5A55A5C
R rd_slot3        3  0  FFFFFFFF
R rd_slot40       28 1F FFFFFFFF
R rd_slot63       3F 0  FFFFFFFF
W wr_fcw          1  1  10000000
W wr_amp          1  3  00004000
W wr_ctrl_saw     1  0  00000000
R rd_fcw          1  1  10000000
R rd_amp          1  3  00004000
R rd_ctrl_saw     1  0  00000000
R rd_ddfs_undef   1  9  00000000
T saw_spaced      14 3  0
T saw_b2b         8  0  0
W wr_poff         1  2  40000000
W wr_fcw_sq       1  1  08000000
W wr_ctrl_sq      1  0  00000002
R rd_poff         1  2  40000000
R rd_ctrl_sq      1  0  00000002
T square_period   20 1  0
W wr_attack       2  0  00001000
W wr_decay        2  1  00000800
W wr_sustain      2  2  00004000
W wr_release      2  3  00000C00
R rd_sustain      2  2  00004000
W wr_ctrl_env     1  0  00000001
W wr_gate_start   2  4  00000001
R rd_gpo_spacer   0  0  A5A55A5C
T attack_ramp     7  2  0
R rd_env_attack   2  5  00017000
T attack_peak     1  0  0
R rd_env_peak     2  5  00027FFF
T decay_part      3  1  0
R rd_env_decay    2  5  000267FF
T decay_rest      5  0  0
R rd_env_sustain  2  5  00034000
T sustain_hold    6  3  0
R rd_env_hold     2  5  00034000
W wr_gate_release 2  4  00000002
R rd_gpo_spacer2  0  0  A5A55A5C
T release_part    4  1  0
R rd_env_release  2  5  00041000
T release_end     2  0  0
R rd_env_idle     2  5  00000000

//--- tb/mmio_checker.sv
`timescale 1ns/100ps
`default_nettype none
`include "io_mmio_map_defs.svh"

module mmio_checker
    import mmio_pkg::*;
(
    input  logic                    i_clk,
    input  logic                    i_arst_n,
    input  logic                    i_mmio_cs,
    input  logic                    i_mmio_write,
    input  logic                    i_mmio_read,
    input  logic [`MMIO_ADDR_W-1:0] i_mmio_addr,
    input  logic [`MMIO_DATA_W-1:0] i_mmio_write_data,
    input  logic [`MMIO_DATA_W-1:0] i_mmio_read_data,
    input  logic [`MMIO_DATA_W-1:0] i_exp_read_data,
    input  logic                    i_sample_tick,
    input  logic [3:0]              i_led,
    input  logic [15:0]             i_pcm_out,
    input  logic                    i_pcm_valid
);

    // Register and synthesizer model
    bit [31:0]   gpo;
    bit [2:0]    ctrl;
    bit [31:0]   fcw;
    bit [31:0]   poff;
    bit [15:0]   amp;
    bit [15:0]   atk;
    bit [15:0]   dec;
    bit [15:0]   sus;
    bit [15:0]   rel;
    bit [31:0]   phase;
    bit [15:0]   env;
    adsr_state_e state;
    bit          start_pend;
    bit          rel_pend;
    bit [15:0]   pcm_exp;
    bit          valid_exp;

    string cur_name = "none";
    int    cur_errors;
    int    tests_passed;
    int    tests_failed;

    task automatic start_test(input string name);
        cur_name   = name;
        cur_errors = 0;
    endtask

    task automatic finish_test();
        if (cur_errors == 0) begin
            tests_passed++;
            $display("Test %-16s ok", cur_name);
        end else begin
            tests_failed++;
            $display("Test %-16s failed with %0d errors", cur_name, cur_errors);
        end
    endtask

    task automatic print_totals();
        $display("Tests run %0d, passed %0d, failed %0d",
                 tests_passed + tests_failed, tests_passed, tests_failed);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        if (act !== exp) begin
            cur_errors++;
            $display("Mismatch %s %s: expected %h, actual %h", cur_name, what, exp, act);
        end
    endtask

    // Waveform times unsigned gain, then >>> 15
    function automatic bit [15:0] sample_of(input bit [31:0] ph, input bit square,
                                            input bit [15:0] gain);
        longint w;
        longint p;
        if (square) begin
            w = ph[31] ? -32767 : 32767;
        end else begin
            w = $signed(ph[31:16]);
        end
        p = w * longint'(gain);
        p = p >>> 15;
        return p[15:0];
    endfunction

    always @(posedge i_clk) begin : monitor
        logic [`MMIO_SLOT_W-1:0] slot;
        logic [`MMIO_REG_W-1:0]  rnum;
        bit                      wr;
        int                      up;
        int                      down;

        slot = i_mmio_addr[`MMIO_SLOT_LSB +: `MMIO_SLOT_W];
        rnum = i_mmio_addr[`MMIO_REG_W-1:0];
        wr   = i_mmio_cs && i_mmio_write;

        // Outputs as they stood before this edge
        check_value("pcm_valid", valid_exp, i_pcm_valid);
        check_value("pcm_out", pcm_exp, i_pcm_out);
        check_value("led", gpo[3:0], i_led);
        if (i_arst_n && i_mmio_cs && i_mmio_read) begin
            check_value("read data", i_exp_read_data, i_mmio_read_data);
        end

        if (!i_arst_n) begin
            gpo        = '0;
            ctrl       = '0;
            fcw        = '0;
            poff       = '0;
            amp        = '0;
            atk        = '0;
            dec        = '0;
            sus        = '0;
            rel        = '0;
            phase      = '0;
            env        = '0;
            state      = ADSR_IDLE;
            start_pend = 1'b0;
            rel_pend   = 1'b0;
            pcm_exp    = '0;
            valid_exp  = 1'b0;
        end else begin
            valid_exp = i_sample_tick;
            if (i_sample_tick) begin
                pcm_exp = sample_of(phase + poff, ctrl[2:1] == WAVE_SQUARE,
                                    ctrl[0] ? env : amp);
                phase   = phase + fcw;
            end

            // Gate commands win over the tick
            if (start_pend) begin
                state = ADSR_ATTACK;
            end else if (rel_pend && state != ADSR_IDLE) begin
                state = ADSR_RELEASE;
            end else if (i_sample_tick) begin
                up = int'(env) + int'(atk);
                case (state)
                    ADSR_ATTACK: begin
                        if (up >= int'(`ENV_MAX)) begin
                            env   = `ENV_MAX;
                            state = ADSR_DECAY;
                        end else begin
                            env = up[15:0];
                        end
                    end
                    ADSR_DECAY: begin
                        down = int'(env) - int'(dec);
                        if (down <= int'(sus)) begin
                            env   = sus;
                            state = ADSR_SUSTAIN;
                        end else begin
                            env = down[15:0];
                        end
                    end
                    ADSR_RELEASE: begin
                        down = int'(env) - int'(rel);
                        if (down <= 0) begin
                            env   = '0;
                            state = ADSR_IDLE;
                        end else begin
                            env = down[15:0];
                        end
                    end
                    default: ;
                endcase
            end

            start_pend = wr && slot == `IO_S2_ADSR && rnum == `ADSR_REG_GATE
                         && i_mmio_write_data[0];
            rel_pend   = wr && slot == `IO_S2_ADSR && rnum == `ADSR_REG_GATE
                         && i_mmio_write_data[1];

            if (wr && slot == `IO_S0_GPO) begin
                gpo = i_mmio_write_data;
            end else if (wr && slot == `IO_S1_DDFS) begin
                case (rnum)
                    `DDFS_REG_CTRL: ctrl = i_mmio_write_data[2:0];
                    `DDFS_REG_FCW:  fcw  = i_mmio_write_data;
                    `DDFS_REG_POFF: poff = i_mmio_write_data;
                    `DDFS_REG_AMP:  amp  = i_mmio_write_data[15:0];
                    default: ;
                endcase
            end else if (wr && slot == `IO_S2_ADSR) begin
                case (rnum)
                    `ADSR_REG_ATTACK:  atk = i_mmio_write_data[15:0];
                    `ADSR_REG_DECAY:   dec = i_mmio_write_data[15:0];
                    `ADSR_REG_SUSTAIN: sus = i_mmio_write_data[15:0];
                    `ADSR_REG_RELEASE: rel = i_mmio_write_data[15:0];
                    default: ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- tb/tb_mmio_top.sv
`timescale 1ns/100ps
`default_nettype none
`include "io_mmio_map_defs.svh"

module tb_mmio_top;

    logic                    clk;
    logic                    arst_n;
    logic                    mmio_cs;
    logic                    mmio_write;
    logic                    mmio_read;
    logic [`MMIO_ADDR_W-1:0] mmio_addr;
    logic [`MMIO_DATA_W-1:0] mmio_write_data;
    logic [`MMIO_DATA_W-1:0] mmio_read_data;
    logic [`MMIO_DATA_W-1:0] exp_read_data;
    logic                    sample_tick;
    logic [3:0]              led;
    logic [15:0]             pcm_out;
    logic                    pcm_valid;

    // Parsed case file
    string       case_op[$];
    string       case_name[$];
    logic [31:0] case_a[$];
    logic [31:0] case_b[$];
    logic [31:0] case_c[$];

    integer seed;
    int     budget_ns;
    bit     ok;

    mmio_top u_mmio_top (
        .i_clk             (clk),
        .i_arst_n          (arst_n),
        .i_mmio_cs         (mmio_cs),
        .i_mmio_write      (mmio_write),
        .i_mmio_read       (mmio_read),
        .i_mmio_addr       (mmio_addr),
        .i_mmio_write_data (mmio_write_data),
        .o_mmio_read_data  (mmio_read_data),
        .i_sample_tick     (sample_tick),
        .o_led             (led),
        .o_pcm_out         (pcm_out),
        .o_pcm_valid       (pcm_valid)
    );

    mmio_checker u_checker (
        .i_clk             (clk),
        .i_arst_n          (arst_n),
        .i_mmio_cs         (mmio_cs),
        .i_mmio_write      (mmio_write),
        .i_mmio_read       (mmio_read),
        .i_mmio_addr       (mmio_addr),
        .i_mmio_write_data (mmio_write_data),
        .i_mmio_read_data  (mmio_read_data),
        .i_exp_read_data   (exp_read_data),
        .i_sample_tick     (sample_tick),
        .i_led             (led),
        .i_pcm_out         (pcm_out),
        .i_pcm_valid       (pcm_valid)
    );

    always #20 clk = ~clk;

    task automatic load_cases(output bit good);
        int    fd;
        int    n;
        string line;
        string op;
        string name;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        int    cycles;

        good   = 1'b1;
        cycles = 4;
        fd     = $fopen("tb/mmio_cases.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the case file tb/mmio_cases.txt");
            good = 1'b0;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                n    = $fgets(line, fd);
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %s %h %h %h", op, name, a, b, c);
                    if (n == 5 && (op == "W" || op == "R" || op == "T")) begin
                        case_op.push_back(op);
                        case_name.push_back(name);
                        case_a.push_back(a);
                        case_b.push_back(b);
                        case_c.push_back(c);
                        cycles += (op == "T") ? a * (b + 1) + 2 : 2;
                    end else begin
                        $display("Case file line cannot be parsed: %s", line);
                        good = 1'b0;
                    end
                end
            end
            $fclose(fd);
            if (case_op.size() == 0) begin
                $display("Case file holds no cases");
                good = 1'b0;
            end
        end
        // Whole run plus some slack
        budget_ns = cycles * 40 + 1000;
    endtask

    task automatic bus_access(input bit is_write, input logic [31:0] slot,
                              input logic [31:0] rnum, input logic [31:0] data);
        @(negedge clk);
        mmio_cs         = 1'b1;
        mmio_write      = is_write;
        mmio_read       = !is_write;
        mmio_addr       = '0;
        mmio_addr[`MMIO_SLOT_LSB +: `MMIO_SLOT_W] = slot[`MMIO_SLOT_W-1:0];
        mmio_addr[`MMIO_REG_W-1:0]                = rnum[`MMIO_REG_W-1:0];
        mmio_write_data = is_write ? data : '0;
        exp_read_data   = is_write ? '0 : data;
        @(negedge clk);
        mmio_cs    = 1'b0;
        mmio_write = 1'b0;
        mmio_read  = 1'b0;
    endtask

    // Up to max_gap idle cycles between ticks, zero gives back-to-back
    task automatic tick_burst(input int count, input int max_gap);
        int idle;
        for (int i = 0; i < count; i++) begin
            @(negedge clk);
            sample_tick = 1'b1;
            idle = $unsigned($random(seed)) % (max_gap + 1);
            if (i == count - 1) begin
                idle = 0;
            end
            if (idle > 0) begin
                @(negedge clk);
                sample_tick = 1'b0;
                repeat (idle - 1) @(negedge clk);
            end
        end
        @(negedge clk);
        sample_tick = 1'b0;
        // Let the last sample reach the checker
        @(negedge clk);
    endtask

    initial begin
        wait (budget_ns > 0);
        #(budget_ns);
        $display("Timeout: the run did not finish within %0d ns", budget_ns);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        clk             = 1'b0;
        arst_n          = 1'b0;
        mmio_cs         = 1'b0;
        mmio_write      = 1'b0;
        mmio_read       = 1'b0;
        mmio_addr       = '0;
        mmio_write_data = '0;
        exp_read_data   = '0;
        sample_tick     = 1'b0;
        seed            = 15;

        load_cases(ok);
        if (ok) begin
            u_checker.start_test("reset");
            repeat (2) @(negedge clk);
            arst_n = 1'b1;
            repeat (2) @(negedge clk);
            u_checker.finish_test();

            foreach (case_op[i]) begin
                u_checker.start_test(case_name[i]);
                if (case_op[i] == "T") begin
                    tick_burst(case_a[i], case_b[i]);
                end else begin
                    bus_access(case_op[i] == "W", case_a[i], case_b[i], case_c[i]);
                end
                u_checker.finish_test();
            end
        end

        u_checker.print_totals();
        if (ok && u_checker.tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
